// ==== rtl/collide_consts.svh ====
`ifndef COLLIDE_CONSTS_SVH
`define COLLIDE_CONSTS_SVH

// vertex coordinate and normal formats
`define COORD_W 19
`define NORM_W 10

// dot product of normal and coordinate difference
`define SEP_W 32

// every body is a quad
`define NUM_EDGES 4

// unit box normal magnitude
`define UNIT_NORM 256

// normal scaling per shape kind
`define SHIFT_EVEN 5
`define SHIFT_SHORT 3
`define SHIFT_LONG 6

`endif

// ==== rtl/collidePkg.sv ====
`include "collide_consts.svh"

package collidePkg;

  typedef logic signed [`COORD_W-1:0] coord_t;
  typedef logic signed [`NORM_W-1:0] norm_t;
  typedef logic signed [`SEP_W-1:0] sep_t;

  // face or edge number within one quad
  typedef logic [1:0] edgeIdx_t;

  typedef enum logic [1:0] {
    unitBox,
    evenScale,
    tallRect,
    wideRect
  } shapeKind_e;

  typedef enum logic [1:0] {
    idle,
    faceSearch,
    edgeSearch,
    report
  } collideState_e;

endpackage

// ==== rtl/edgeNormalGen.sv ====
`timescale 1ns/10ps
`include "collide_consts.svh"

module edgeNormalGen
  import collidePkg::*;
(
  input  coord_t     vertX [`NUM_EDGES],
  input  coord_t     vertY [`NUM_EDGES],
  input  shapeKind_e kind,
  output norm_t      normX [`NUM_EDGES],
  output norm_t      normY [`NUM_EDGES]
);

  // one extra bit so the edge difference cannot wrap
  logic signed [`COORD_W:0] rawX [`NUM_EDGES];
  logic signed [`COORD_W:0] rawY [`NUM_EDGES];
  logic signed [`COORD_W:0] scaledX [`NUM_EDGES];
  logic signed [`COORD_W:0] scaledY [`NUM_EDGES];
  logic [2:0] shiftAmt [`NUM_EDGES];

  always_comb begin
    for (int i = 0; i < `NUM_EDGES; i++) begin
      rawX[i] = vertY[i] - vertY[(i + 1) % `NUM_EDGES];
      rawY[i] = vertX[(i + 1) % `NUM_EDGES] - vertX[i];
      // rectangles scale even and odd edges differently
      case (kind)
        tallRect: shiftAmt[i] = (i % 2 == 0) ? 3'(`SHIFT_LONG) : 3'(`SHIFT_SHORT);
        wideRect: shiftAmt[i] = (i % 2 == 0) ? 3'(`SHIFT_SHORT) : 3'(`SHIFT_LONG);
        default:  shiftAmt[i] = 3'(`SHIFT_EVEN);
      endcase
      scaledX[i] = rawX[i] >>> shiftAmt[i];
      scaledY[i] = rawY[i] >>> shiftAmt[i];
    end
  end

  always_comb begin
    if (kind == unitBox) begin
      // fixed outward normals, vertices ignored
      normX[0] = '0;
      normY[0] = norm_t'(-`UNIT_NORM);
      normX[1] = norm_t'(-`UNIT_NORM);
      normY[1] = '0;
      normX[2] = '0;
      normY[2] = norm_t'(`UNIT_NORM);
      normX[3] = norm_t'(`UNIT_NORM);
      normY[3] = '0;
    end else begin
      for (int i = 0; i < `NUM_EDGES; i++) begin
        normX[i] = scaledX[i][`NORM_W-1:0];
        normY[i] = scaledY[i][`NORM_W-1:0];
      end
    end
  end

endmodule

// ==== rtl/separationSearch.sv ====
`timescale 1ns/10ps
`include "collide_consts.svh"

module separationSearch
  import collidePkg::*;
(
  input  logic     clk,
  input  logic     rst_op,
  input  logic     searchStart,
  input  coord_t   refX [`NUM_EDGES],
  input  coord_t   refY [`NUM_EDGES],
  input  coord_t   otherX [`NUM_EDGES],
  input  coord_t   otherY [`NUM_EDGES],
  input  norm_t    normX [`NUM_EDGES],
  input  norm_t    normY [`NUM_EDGES],
  output sep_t     bestSep,
  output edgeIdx_t bestIdx,
  output logic     searchDone
);

  logic     running;
  edgeIdx_t face;
  edgeIdx_t faceSel;
  sep_t     diffX [`NUM_EDGES];
  sep_t     diffY [`NUM_EDGES];
  sep_t     dotVal [`NUM_EDGES];
  sep_t     faceSep;

  // face 0 is evaluated in the start cycle
  assign faceSel = searchStart ? 2'd0 : face;

  always_comb begin
    for (int j = 0; j < `NUM_EDGES; j++) begin
      diffX[j] = sep_t'(otherX[j]) - sep_t'(refX[faceSel]);
      diffY[j] = sep_t'(otherY[j]) - sep_t'(refY[faceSel]);
      dotVal[j] = sep_t'(normX[faceSel]) * diffX[j] + sep_t'(normY[faceSel]) * diffY[j];
    end
  end

  // deepest vertex of the other body against this face
  always_comb begin
    faceSep = dotVal[0];
    for (int j = 1; j < `NUM_EDGES; j++) begin
      if (dotVal[j] < faceSep) begin
        faceSep = dotVal[j];
      end
    end
  end

  always_ff @(posedge clk or posedge rst_op) begin
    if (rst_op) begin
      running <= 1'b0;
      face <= '0;
      searchDone <= 1'b0;
    end else begin
      searchDone <= 1'b0;
      if (searchStart) begin
        running <= 1'b1;
        face <= 2'd1;
      end else if (running) begin
        face <= face + 2'd1;
        if (face == 2'd3) begin
          running <= 1'b0;
          searchDone <= 1'b1;
        end
      end
    end
  end

  // strict compare keeps the lowest face on a tie
  always_ff @(posedge clk) begin
    if (searchStart) begin
      bestSep <= faceSep;
      bestIdx <= '0;
    end else if (running && faceSep > bestSep) begin
      bestSep <= faceSep;
      bestIdx <= face;
    end
  end

  // controller must wait for searchDone before restarting
  assert property (@(posedge clk) disable iff (rst_op) running |-> !searchStart);

endmodule

// ==== rtl/incidentEdgeSearch.sv ====
`timescale 1ns/10ps
`include "collide_consts.svh"

module incidentEdgeSearch
  import collidePkg::*;
(
  input  logic     clk,
  input  logic     rst_op,
  input  logic     edgeStart,
  input  norm_t    refNormX,
  input  norm_t    refNormY,
  input  norm_t    normX [`NUM_EDGES],
  input  norm_t    normY [`NUM_EDGES],
  output edgeIdx_t incIdx,
  output logic     edgeDone
);

  logic     running;
  edgeIdx_t edgeCnt;
  edgeIdx_t edgeSel;
  logic signed [2*`NORM_W:0] dotVal;
  logic signed [2*`NORM_W:0] minDot;

  // edge 0 checked while edgeStart is high
  assign edgeSel = edgeStart ? 2'd0 : edgeCnt;

  assign dotVal = refNormX * normX[edgeSel] + refNormY * normY[edgeSel];

  always_ff @(posedge clk or posedge rst_op) begin
    if (rst_op) begin
      running <= 1'b0;
      edgeCnt <= '0;
      edgeDone <= 1'b0;
    end else begin
      edgeDone <= 1'b0;
      if (edgeStart) begin
        running <= 1'b1;
        edgeCnt <= 2'd1;
      end else if (running) begin
        edgeCnt <= edgeCnt + 2'd1;
        if (edgeCnt == 2'd3) begin
          running <= 1'b0;
          edgeDone <= 1'b1;
        end
      end
    end
  end

  // most anti-parallel edge, lowest index on ties
  always_ff @(posedge clk) begin
    if (edgeStart) begin
      minDot <= dotVal;
      incIdx <= '0;
    end else if (running && dotVal < minDot) begin
      minDot <= dotVal;
      incIdx <= edgeCnt;
    end
  end

  assert property (@(posedge clk) disable iff (rst_op) edgeDone |=> !edgeDone);

endmodule

// ==== rtl/contactControl.sv ====
`timescale 1ns/10ps
`include "collide_consts.svh"

module contactControl
  import collidePkg::*;
(
  input  logic     clk,
  input  logic     rst_op,
  input  logic     start,
  input  sep_t     sepAB,
  input  sep_t     sepBA,
  input  edgeIdx_t idxAB,
  input  edgeIdx_t idxBA,
  input  logic     searchDone,
  input  norm_t    aNormX [`NUM_EDGES],
  input  norm_t    aNormY [`NUM_EDGES],
  input  norm_t    bNormX [`NUM_EDGES],
  input  norm_t    bNormY [`NUM_EDGES],
  input  edgeIdx_t incIdx,
  input  logic     edgeDone,
  output logic     searchStart,
  output logic     edgeStart,
  output norm_t    refNormX,
  output norm_t    refNormY,
  output norm_t    incNormX [`NUM_EDGES],
  output norm_t    incNormY [`NUM_EDGES],
  output logic     busy,
  output logic     done,
  output logic     contact,
  output logic     flip,
  output edgeIdx_t refIndex,
  output edgeIdx_t incIndex,
  output norm_t    contactNormX,
  output norm_t    contactNormY,
  output sep_t     separation
);

  collideState_e state;
  sep_t     sepABReg;
  sep_t     sepBAReg;
  edgeIdx_t idxABReg;
  edgeIdx_t idxBAReg;
  logic     refIsA;
  logic     touching;
  logic     flipNext;

  // A is the reference body unless B separates strictly more
  assign refIsA = (sepABReg >= sepBAReg);
  assign touching = sepABReg[`SEP_W-1] & sepBAReg[`SEP_W-1];
  assign flipNext = touching & ~refIsA;

  always_comb begin
    if (refIsA) begin
      refNormX = aNormX[idxABReg];
      refNormY = aNormY[idxABReg];
      incNormX = bNormX;
      incNormY = bNormY;
    end else begin
      refNormX = bNormX[idxBAReg];
      refNormY = bNormY[idxBAReg];
      incNormX = aNormX;
      incNormY = aNormY;
    end
  end

  always_ff @(posedge clk) begin
    if (state == faceSearch && searchDone) begin
      sepABReg <= sepAB;
      sepBAReg <= sepBA;
      idxABReg <= idxAB;
      idxBAReg <= idxBA;
    end
  end

  always_ff @(posedge clk or posedge rst_op) begin
    if (rst_op) begin
      state <= idle;
      searchStart <= 1'b0;
      edgeStart <= 1'b0;
      busy <= 1'b0;
      done <= 1'b0;
      contact <= 1'b0;
      flip <= 1'b0;
      refIndex <= '0;
      incIndex <= '0;
      contactNormX <= '0;
      contactNormY <= '0;
      separation <= '0;
    end else begin
      searchStart <= 1'b0;
      edgeStart <= 1'b0;
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state <= faceSearch;
            searchStart <= 1'b1;
            busy <= 1'b1;
          end
        end
        faceSearch: begin
          if (searchDone) begin
            // incident edge only matters when both faces overlap
            if (sepAB[`SEP_W-1] && sepBA[`SEP_W-1]) begin
              state <= edgeSearch;
              edgeStart <= 1'b1;
            end else begin
              state <= report;
            end
          end
        end
        edgeSearch: begin
          if (edgeDone) begin
            state <= report;
          end
        end
        report: begin
          state <= idle;
          busy <= 1'b0;
          done <= 1'b1;
          contact <= touching;
          flip <= flipNext;
          refIndex <= refIsA ? idxABReg : idxBAReg;
          incIndex <= touching ? incIdx : 2'd0;
          // normal always points from A to B
          contactNormX <= flipNext ? -refNormX : refNormX;
          contactNormY <= flipNext ? -refNormY : refNormY;
          separation <= refIsA ? sepABReg : sepBAReg;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst_op) done |-> $past(state) == report);

  assert property (@(posedge clk) disable iff (rst_op) done |-> !busy);

endmodule

// ==== rtl/collideTop.sv ====
`timescale 1ns/10ps
`include "collide_consts.svh"

module collideTop
  import collidePkg::*;
(
  input  logic       clk,
  input  logic       rst_op,
  input  logic       start,
  input  coord_t     aX [`NUM_EDGES],
  input  coord_t     aY [`NUM_EDGES],
  input  coord_t     bX [`NUM_EDGES],
  input  coord_t     bY [`NUM_EDGES],
  input  shapeKind_e aKind,
  input  shapeKind_e bKind,
  output logic       busy,
  output logic       done,
  output logic       contact,
  output logic       flip,
  output edgeIdx_t   refIndex,
  output edgeIdx_t   incIndex,
  output norm_t      contactNormX,
  output norm_t      contactNormY,
  output sep_t       separation
);

  norm_t    aNormX [`NUM_EDGES];
  norm_t    aNormY [`NUM_EDGES];
  norm_t    bNormX [`NUM_EDGES];
  norm_t    bNormY [`NUM_EDGES];
  norm_t    incNormX [`NUM_EDGES];
  norm_t    incNormY [`NUM_EDGES];
  norm_t    refNormX;
  norm_t    refNormY;
  sep_t     sepValAB;
  sep_t     sepValBA;
  edgeIdx_t idxAB;
  edgeIdx_t idxBA;
  edgeIdx_t incIdx;
  logic     searchStart;
  logic     searchDoneAB;
  logic     searchDoneBA;
  logic     searchDone;
  logic     edgeStart;
  logic     edgeDone;

  // both searches run in lockstep
  assign searchDone = searchDoneAB & searchDoneBA;

  edgeNormalGen normGenA (
    .vertX (aX),
    .vertY (aY),
    .kind  (aKind),
    .normX (aNormX),
    .normY (aNormY)
  );

  edgeNormalGen normGenB (
    .vertX (bX),
    .vertY (bY),
    .kind  (bKind),
    .normX (bNormX),
    .normY (bNormY)
  );

  // faces of A against vertices of B
  separationSearch sepAB (
    .clk         (clk),
    .rst_op      (rst_op),
    .searchStart (searchStart),
    .refX        (aX),
    .refY        (aY),
    .otherX      (bX),
    .otherY      (bY),
    .normX       (aNormX),
    .normY       (aNormY),
    .bestSep     (sepValAB),
    .bestIdx     (idxAB),
    .searchDone  (searchDoneAB)
  );

  separationSearch sepBA (
    .clk         (clk),
    .rst_op      (rst_op),
    .searchStart (searchStart),
    .refX        (bX),
    .refY        (bY),
    .otherX      (aX),
    .otherY      (aY),
    .normX       (bNormX),
    .normY       (bNormY),
    .bestSep     (sepValBA),
    .bestIdx     (idxBA),
    .searchDone  (searchDoneBA)
  );

  incidentEdgeSearch incSearch (
    .clk      (clk),
    .rst_op   (rst_op),
    .edgeStart(edgeStart),
    .refNormX (refNormX),
    .refNormY (refNormY),
    .normX    (incNormX),
    .normY    (incNormY),
    .incIdx   (incIdx),
    .edgeDone (edgeDone)
  );

  contactControl ctrl (
    .clk          (clk),
    .rst_op       (rst_op),
    .start        (start),
    .sepAB        (sepValAB),
    .sepBA        (sepValBA),
    .idxAB        (idxAB),
    .idxBA        (idxBA),
    .searchDone   (searchDone),
    .aNormX       (aNormX),
    .aNormY       (aNormY),
    .bNormX       (bNormX),
    .bNormY       (bNormY),
    .incIdx       (incIdx),
    .edgeDone     (edgeDone),
    .searchStart  (searchStart),
    .edgeStart    (edgeStart),
    .refNormX     (refNormX),
    .refNormY     (refNormY),
    .incNormX     (incNormX),
    .incNormY     (incNormY),
    .busy         (busy),
    .done         (done),
    .contact      (contact),
    .flip         (flip),
    .refIndex     (refIndex),
    .incIndex     (incIndex),
    .contactNormX (contactNormX),
    .contactNormY (contactNormY),
    .separation   (separation)
  );

endmodule

// ==== sim/collideTb.sv ====
`timescale 1ns/10ps
`include "collide_consts.svh"

module collideTb
  import collidePkg::*;
();

  localparam int NUM_TESTS = 200;
  localparam int CYCLE_LIMIT = NUM_TESTS * 20 + 100;

  logic       clk = 1'b0;
  logic       rst_op;
  logic       start;
  coord_t     aX [`NUM_EDGES];
  coord_t     aY [`NUM_EDGES];
  coord_t     bX [`NUM_EDGES];
  coord_t     bY [`NUM_EDGES];
  shapeKind_e aKind;
  shapeKind_e bKind;
  logic       busy;
  logic       done;
  logic       contact;
  logic       flip;
  edgeIdx_t   refIndex;
  edgeIdx_t   incIndex;
  norm_t      contactNormX;
  norm_t      contactNormY;
  sep_t       separation;

  // model view, body 0 is A and body 1 is B
  int         vx [2][`NUM_EDGES];
  int         vy [2][`NUM_EDGES];
  int         nx [2][`NUM_EDGES];
  int         ny [2][`NUM_EDGES];
  shapeKind_e kinds [2];
  logic       expContact;
  logic       expFlip;
  int         expRefIdx;
  int         expIncIdx;
  norm_t      expNormX;
  norm_t      expNormY;
  sep_t       expSep;

  int seed;
  int curTest;
  int cycleCount = 0;
  int valueErrors;
  int protocolErrors;
  int contactCount;

  // rotation steps of 22.5 degrees, scaled by 64
  int cosTab [8] = '{64, 59, 45, 24, 0, -24, -45, -59};
  int sinTab [8] = '{0, 24, 45, 59, 64, 59, 45, 24};

  collideTop dut_i (
    .clk          (clk),
    .rst_op       (rst_op),
    .start        (start),
    .aX           (aX),
    .aY           (aY),
    .bX           (bX),
    .bY           (bY),
    .aKind        (aKind),
    .bKind        (bKind),
    .busy         (busy),
    .done         (done),
    .contact      (contact),
    .flip         (flip),
    .refIndex     (refIndex),
    .incIndex     (incIndex),
    .contactNormX (contactNormX),
    .contactNormY (contactNormY),
    .separation   (separation)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int randRange(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'($unsigned($random(seed)) % span);
  endfunction

  function automatic int shiftFor(input shapeKind_e kind, input int e);
    if (kind == tallRect) begin
      return (e % 2 == 0) ? `SHIFT_LONG : `SHIFT_SHORT;
    end
    if (kind == wideRect) begin
      return (e % 2 == 0) ? `SHIFT_SHORT : `SHIFT_LONG;
    end
    return `SHIFT_EVEN;
  endfunction

  // arithmetic shift, then keep the low normal bits
  function automatic int normalComp(input int raw, input int shift);
    norm_t trunc;
    trunc = norm_t'(raw >>> shift);
    return int'(trunc);
  endfunction

  task automatic makeBody(input int b, input int cx, input int cy);
    int hw;
    int hh;
    int rot;
    int ox [`NUM_EDGES];
    int oy [`NUM_EDGES];
    hw = randRange(32, 543);
    hh = randRange(32, 543);
    rot = (randRange(0, 1) == 1) ? randRange(1, 7) : 0;
    // corner order keeps edge 0 at the bottom face
    ox = '{hw, -hw, -hw, hw};
    oy = '{-hh, -hh, hh, hh};
    for (int i = 0; i < `NUM_EDGES; i++) begin
      vx[b][i] = cx + (ox[i] * cosTab[rot] - oy[i] * sinTab[rot]) / 64;
      vy[b][i] = cy + (ox[i] * sinTab[rot] + oy[i] * cosTab[rot]) / 64;
    end
    kinds[b] = shapeKind_e'(randRange(0, 3));
  endtask

  task automatic buildNormals(input int b);
    int n;
    for (int e = 0; e < `NUM_EDGES; e++) begin
      n = (e + 1) % `NUM_EDGES;
      if (kinds[b] == unitBox) begin
        nx[b][e] = (e == 1) ? -`UNIT_NORM : ((e == 3) ? `UNIT_NORM : 0);
        ny[b][e] = (e == 0) ? -`UNIT_NORM : ((e == 2) ? `UNIT_NORM : 0);
      end else begin
        nx[b][e] = normalComp(vy[b][e] - vy[b][n], shiftFor(kinds[b], e));
        ny[b][e] = normalComp(vx[b][n] - vx[b][e], shiftFor(kinds[b], e));
      end
    end
  endtask

  // deepest vertex of body 1-p measured against face f of body p
  function automatic longint faceSeparation(input int p, input int f);
    longint minDot;
    longint d;
    int q;
    q = 1 - p;
    minDot = 0;
    for (int j = 0; j < `NUM_EDGES; j++) begin
      d = longint'(nx[p][f]) * (vx[q][j] - vx[p][f])
        + longint'(ny[p][f]) * (vy[q][j] - vy[p][f]);
      if (j == 0 || d < minDot) begin
        minDot = d;
      end
    end
    return minDot;
  endfunction

  task automatic bestFace(input int p, output longint sep, output int idx);
    longint s;
    sep = faceSeparation(p, 0);
    idx = 0;
    for (int f = 1; f < `NUM_EDGES; f++) begin
      s = faceSeparation(p, f);
      if (s > sep) begin
        sep = s;
        idx = f;
      end
    end
  endtask

  task automatic computeExpected();
    longint sepAB;
    longint sepBA;
    longint d;
    longint minDot;
    int idxAB;
    int idxBA;
    int refBody;
    int incBody;
    int incK;
    int rnx;
    int rny;
    logic refIsA;
    bestFace(0, sepAB, idxAB);
    bestFace(1, sepBA, idxBA);
    expContact = (sepAB < 0) && (sepBA < 0);
    refIsA = (sepAB >= sepBA);
    expFlip = expContact && !refIsA;
    expRefIdx = refIsA ? idxAB : idxBA;
    refBody = refIsA ? 0 : 1;
    incBody = 1 - refBody;
    rnx = nx[refBody][expRefIdx];
    rny = ny[refBody][expRefIdx];
    incK = 0;
    minDot = 0;
    // most anti-parallel edge of the incident body
    for (int k = 0; k < `NUM_EDGES; k++) begin
      d = longint'(rnx) * nx[incBody][k] + longint'(rny) * ny[incBody][k];
      if (k == 0 || d < minDot) begin
        minDot = d;
        incK = k;
      end
    end
    expIncIdx = expContact ? incK : 0;
    expNormX = expFlip ? norm_t'(-rnx) : norm_t'(rnx);
    expNormY = expFlip ? norm_t'(-rny) : norm_t'(rny);
    expSep = sep_t'(refIsA ? sepAB : sepBA);
  endtask

  task automatic generateTest(input int t);
    int cx;
    int cy;
    int dx;
    int dy;
    cx = randRange(-2000, 2000);
    cy = randRange(-2000, 2000);
    makeBody(0, cx, cy);
    if (t % 10 == 9) begin
      // identical bodies, so sepAB equals sepBA
      vx[1] = vx[0];
      vy[1] = vy[0];
      kinds[1] = kinds[0];
    end else begin
      // offset range tuned for roughly even overlap
      dx = randRange(-800, 800);
      dy = randRange(-800, 800);
      makeBody(1, cx + dx, cy + dy);
    end
    buildNormals(0);
    buildNormals(1);
    computeExpected();
    if (expContact) begin
      contactCount++;
    end
  endtask

  task automatic applyInputs();
    for (int i = 0; i < `NUM_EDGES; i++) begin
      aX[i] = coord_t'(vx[0][i]);
      aY[i] = coord_t'(vy[0][i]);
      bX[i] = coord_t'(vx[1][i]);
      bY[i] = coord_t'(vy[1][i]);
    end
    aKind = kinds[0];
    bKind = kinds[1];
  endtask

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] gotVal);
    assert (gotVal === expVal) else begin
      valueErrors++;
      $display("[ERROR] test %0d %s: expected %h, got %h", curTest, name, expVal, gotVal);
    end
  endtask

  function automatic logic [57:0] outputWord();
    return {contact, flip, refIndex, incIndex, contactNormX, contactNormY, separation};
  endfunction

  task automatic checkOutputs();
    checkValue("busy", 32'(1'b0), 32'(busy));
    checkValue("contact", 32'(expContact), 32'(contact));
    checkValue("flip", 32'(expFlip), 32'(flip));
    checkValue("refIndex", 32'(expRefIdx), 32'(refIndex));
    checkValue("incIndex", 32'(expIncIdx), 32'(incIndex));
    checkValue("contactNormX", 32'(expNormX), 32'(contactNormX));
    checkValue("contactNormY", 32'(expNormY), 32'(contactNormY));
    checkValue("separation", 32'(expSep), 32'(separation));
  endtask

  task automatic runTest(input int t);
    int waited;
    logic [57:0] snap;
    @(negedge clk);
    applyInputs();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    waited = 1;
    while (done !== 1'b1 && waited <= 16) begin
      assert (busy === 1'b1) else begin
        protocolErrors++;
        $display("busy was low before done in test %0d", t);
      end
      @(negedge clk);
      waited++;
      // every fourth test repeats start while busy
      start = (t % 4 == 1 && waited == 2) ? 1'b1 : 1'b0;
    end
    assert (done === 1'b1) else begin
      protocolErrors++;
      $display("done did not arrive within 16 cycles of start in test %0d", t);
    end
    if (done === 1'b1) begin
      checkOutputs();
      snap = outputWord();
      repeat (randRange(1, 3)) begin
        @(negedge clk);
        assert (done === 1'b0) else begin
          protocolErrors++;
          $display("done was high for more than one cycle in test %0d", t);
        end
        // an ignored start must not launch a second run
        assert (busy === 1'b0) else begin
          protocolErrors++;
          $display("busy rose again after done without a new start in test %0d", t);
        end
        assert (outputWord() === snap) else begin
          valueErrors++;
          $display("[ERROR] test %0d held outputs: expected %h, got %h", t, snap, outputWord());
        end
      end
    end
  endtask

  initial begin
    seed = 32'ha7e3;
    valueErrors = 0;
    protocolErrors = 0;
    contactCount = 0;
    curTest = -1;
    rst_op = 1'b1;
    start = 1'b0;
    aKind = unitBox;
    bKind = unitBox;
    for (int i = 0; i < `NUM_EDGES; i++) begin
      aX[i] = '0;
      aY[i] = '0;
      bX[i] = '0;
      bY[i] = '0;
    end
    repeat (10) @(negedge clk);
    rst_op = 1'b0;
    @(negedge clk);

    // idle state straight out of reset
    checkValue("busy", 32'(1'b0), 32'(busy));
    checkValue("done", 32'(1'b0), 32'(done));
    checkValue("contact", 32'(1'b0), 32'(contact));
    checkValue("flip", 32'(1'b0), 32'(flip));
    checkValue("refIndex", 32'(0), 32'(refIndex));
    checkValue("incIndex", 32'(0), 32'(incIndex));
    checkValue("contactNormX", 32'(0), 32'(contactNormX));
    checkValue("contactNormY", 32'(0), 32'(contactNormY));
    checkValue("separation", 32'(0), 32'(separation));

    for (int t = 0; t < NUM_TESTS; t++) begin
      curTest = t;
      generateTest(t);
      runTest(t);
    end

    $display("tests %0d, contacts %0d, value errors %0d, protocol errors %0d",
             NUM_TESTS, contactCount, valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== collide.f ====
+incdir+rtl
rtl/collidePkg.sv
rtl/edgeNormalGen.sv
rtl/separationSearch.sv
rtl/incidentEdgeSearch.sv
rtl/contactControl.sv
rtl/collideTop.sv
sim/collideTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = collideTb
FILELIST = collide.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
